// ==== dv/led_axi_stimulus.txt ====
// op 1 write: id addr len bresp, then strb data per beat; op 3 led check: value
// op 2 read: id addr len, then rresp rdata per beat; op 0 ends the run
// reset values of all four registers
2 1 0 3  0 0  0 0  0 0  0 0
// single write, led takes the low four bits of register 0
1 2 0 0 0  f 12345675
3 5
// four beats with partial strobes, then read back
1 3 0 3 0  3 aabbccdd  c 11223344  5 55667788  a 99aabbcc
2 4 0 3  0 1234ccdd  0 11220000  0 00660088  0 9900bb00
3 d
// burst from 0x8 runs past the register block
1 5 8 3 3  f 0000aaaa  f bbbb0000  f deadbeef  f cafef00d
2 6 8 3  0 0000aaaa  0 bbbb0000  3 0  3 0
3 d
// mixed bursts under random bready and rready stalls
1 7 0 1 0  f 0000000a  1 000000ff
3 a
2 8 0 3  0 0000000a  0 112200ff  0 0000aaaa  0 bbbb0000
1 9 4 2 0  f 01010101  6 12345678  8 ffeeddcc
2 a 4 2  0 01010101  0 003456aa  0 ffbb0000
1 b 0 0 0  1 000000f3
3 3
// sixteen beats, only the first four land in registers
1 c 0 f 3  f 6  f 11111111  f 22222222  f 33333333
f 4  f 5  f 6  f 7  f 8  f 9  f a  f b  f c  f d  f e  f f
2 d 0 f  0 6  0 11111111  0 22222222  0 33333333
3 0  3 0  3 0  3 0  3 0  3 0  3 0  3 0  3 0  3 0  3 0  3 0
3 6
2 e 0 0  0 6
2 f 40 1  3 0  3 0
0

// ==== compile.f ====
+incdir+verilog
verilog/led_axi_pkg.sv
verilog/led_axi_if.sv
verilog/cmd_fifo.sv
verilog/led_register_file.sv
verilog/axi_burst_splitter.sv
verilog/led_axi_top.sv
dv/led_axi_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= led_axi_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= No errors

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/led_axi_tb.sv ====
`timescale 1ns/100ps

module led_axi_tb import led_axi_pkg::*; ();

    localparam int STIM_WORDS = 512;
    localparam int TIMEOUT    = 2000; // cycles allowed for any one wait

    localparam logic [31:0] OP_WRITE = 32'd1;
    localparam logic [31:0] OP_READ  = 32'd2;
    localparam logic [31:0] OP_LED   = 32'd3;

    logic  clk;
    logic  reset   = 1'b1;
    id_t   awid    = '0;
    addr_t awaddr  = '0;
    len_t  awlen   = '0;
    logic  awvalid = 1'b0;
    logic  awready;
    data_t wdata   = '0;
    strb_t wstrb   = '0;
    logic  wlast   = 1'b0;
    logic  wvalid  = 1'b0;
    logic  wready;
    id_t   bid;
    resp_t bresp;
    logic  bvalid;
    logic  bready  = 1'b0;
    id_t   arid    = '0;
    addr_t araddr  = '0;
    len_t  arlen   = '0;
    logic  arvalid = 1'b0;
    logic  arready;
    id_t   rid;
    data_t rdata;
    resp_t rresp;
    logic  rlast;
    logic  rvalid;
    logic  rready  = 1'b0;
    led_t  led;

    logic [31:0] stim [STIM_WORDS]; // flat word stream, one record after another
    int          pos         = 0;
    int          error_count = 0;

    led_axi_top u_led_axi_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] next_word();
        next_word = stim[pos];
        pos++;
    endfunction

    task automatic stop_on_error(input string why);
        error_count++;
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_on_error($sformatf("Fail %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    // one AXI burst, write or read, with its expected responses from the stimulus
    task automatic run_burst(input logic is_read);
        id_t   id;
        addr_t addr;
        len_t  len;
        resp_t exp_resp;
        int    cycles;
        id   = id_t'(next_word());
        addr = addr_t'(next_word());
        len  = len_t'(next_word());
        if (!is_read) exp_resp = resp_t'(next_word()); // bresp for the whole burst
        awid    <= id;
        awaddr  <= addr;
        awlen   <= len;
        arid    <= id;
        araddr  <= addr;
        arlen   <= len;
        awvalid <= !is_read;
        arvalid <= is_read;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) stop_on_error(is_read ? "timeout waiting for arready"
                                                        : "timeout waiting for awready");
        end while (!(is_read ? arready : awready));
        awvalid <= 1'b0;
        arvalid <= 1'b0;
        for (int beat = 0; beat <= int'(len); beat++) begin
            if (is_read) begin
                exp_resp = resp_t'(next_word());
                cycles = 0;
                do begin
                    rready <= ($urandom % 4) != 0; // stall about one cycle in four
                    @(posedge clk);
                    cycles++;
                    if (cycles > TIMEOUT) stop_on_error("timeout waiting for rvalid");
                end while (!(rvalid && rready));
                check_value("rid", 32'(rid), 32'(id));
                check_value("rresp", 32'(rresp), 32'(exp_resp));
                check_value("rdata", 32'(rdata), next_word());
                check_value("rlast", 32'(rlast), 32'(beat == int'(len)));
            end else begin
                wstrb  <= strb_t'(next_word());
                wdata  <= data_t'(next_word());
                wlast  <= (beat == int'(len));
                wvalid <= 1'b1;
                cycles = 0;
                do begin
                    @(posedge clk);
                    cycles++;
                    if (cycles > TIMEOUT) stop_on_error("timeout waiting for wready");
                end while (!wready);
            end
        end
        wvalid <= 1'b0;
        rready <= 1'b0;
        if (!is_read) begin
            cycles = 0;
            do begin
                bready <= ($urandom % 4) != 0;
                @(posedge clk);
                cycles++;
                if (cycles > TIMEOUT) stop_on_error("timeout waiting for bvalid");
            end while (!(bvalid && bready));
            bready <= 1'b0;
            check_value("bid", 32'(bid), 32'(id));
            check_value("bresp", 32'(bresp), 32'(exp_resp));
        end
    endtask

    initial begin
        logic [31:0] op;
        void'($urandom(32'he903));
        $readmemh("dv/led_axi_stimulus.txt", stim);
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_value("led", 32'(led), 32'h0);
        check_value("bvalid", 32'(bvalid), 32'h0);
        check_value("rvalid", 32'(rvalid), 32'h0);
        check_value("awready", 32'(awready), 32'h1);
        op = next_word();
        while (op !== 32'd0) begin
            case (op)
                OP_WRITE: run_burst(1'b0);
                OP_READ:  run_burst(1'b1);
                OP_LED:   check_value("led", 32'(led), next_word());
                default:  stop_on_error($sformatf("unknown operation %h in stimulus file", op));
            endcase
            op = next_word();
        end
        if (pos < 2) stop_on_error("stimulus file held no transactions");
        repeat (2) @(posedge clk);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== verilog/led_axi_top.sv ====
`timescale 1ns/100ps

module led_axi_top import led_axi_pkg::*; (
    input  logic  clk,
    input  logic  reset,

    input  id_t   awid,
    input  addr_t awaddr,
    input  len_t  awlen,
    input  logic  awvalid,
    output logic  awready,

    input  data_t wdata,
    input  strb_t wstrb,
    input  logic  wlast,
    input  logic  wvalid,
    output logic  wready,

    output id_t   bid,
    output resp_t bresp,
    output logic  bvalid,
    input  logic  bready,

    input  id_t   arid,
    input  addr_t araddr,
    input  len_t  arlen,
    input  logic  arvalid,
    output logic  arready,

    output id_t   rid,
    output data_t rdata,
    output resp_t rresp,
    output logic  rlast,
    output logic  rvalid,
    input  logic  rready,

    output led_t  led
);

    cmd_if cmd_in ();  // splitter to fifo
    cmd_if cmd_out (); // fifo to register file
    rsp_if rsp_beat ();

    axi_burst_splitter u_axi_burst_splitter (
        .clk     (clk),
        .reset   (reset),
        .awid    (awid),
        .awaddr  (awaddr),
        .awlen   (awlen),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wlast   (wlast),
        .wvalid  (wvalid),
        .wready  (wready),
        .bid     (bid),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .arid    (arid),
        .araddr  (araddr),
        .arlen   (arlen),
        .arvalid (arvalid),
        .arready (arready),
        .rid     (rid),
        .rdata   (rdata),
        .rresp   (rresp),
        .rlast   (rlast),
        .rvalid  (rvalid),
        .rready  (rready),
        .cmd     (cmd_in.src),
        .rsp     (rsp_beat.dst)
    );

    cmd_fifo u_cmd_fifo (
        .clk   (clk),
        .reset (reset),
        .wr    (cmd_in.dst),
        .rd    (cmd_out.src)
    );

    led_register_file u_led_register_file (
        .clk   (clk),
        .reset (reset),
        .cmd   (cmd_out.dst),
        .rsp   (rsp_beat.src),
        .led   (led)
    );

endmodule

// ==== verilog/axi_burst_splitter.sv ====
`timescale 1ns/100ps

`include "led_axi_config.svh"

module axi_burst_splitter import led_axi_pkg::*; (
    input  logic  clk,
    input  logic  reset,

    input  id_t   awid,
    input  addr_t awaddr,
    input  len_t  awlen,
    input  logic  awvalid,
    output logic  awready,

    input  data_t wdata,
    input  strb_t wstrb,
    input  logic  wlast,
    input  logic  wvalid,
    output logic  wready,

    output id_t   bid,
    output resp_t bresp,
    output logic  bvalid,
    input  logic  bready,

    input  id_t   arid,
    input  addr_t araddr,
    input  len_t  arlen,
    input  logic  arvalid,
    output logic  arready,

    output id_t   rid,
    output data_t rdata,
    output resp_t rresp,
    output logic  rlast,
    output logic  rvalid,
    input  logic  rready,

    cmd_if.src    cmd,
    rsp_if.dst    rsp
);

    localparam int CNT_W = $clog2(`MAX_BURST);

    splitter_state_t  state;
    id_t              id_q;
    addr_t            addr_q;      // address of the next beat
    logic [CNT_W-1:0] beats_left;
    logic             rd_issued;   // all read commands pushed
    resp_t            worst_resp;
    resp_t            merged_resp;
    logic             cmd_push;
    logic             wr_rsp_take;

    assign awready = (state == ST_IDLE);
    assign arready = (state == ST_IDLE) && !awvalid; // write wins a tie
    assign wready  = (state == ST_WR_BEATS) && cmd.ready;

    assign cmd.valid   = ((state == ST_WR_BEATS) && wvalid) ||
                         ((state == ST_RD_BEATS) && !rd_issued);
    assign cmd.is_read = (state == ST_RD_BEATS);
    assign cmd.addr    = addr_q;
    assign cmd.wdata   = wdata;
    assign cmd.wstrb   = cmd.is_read ? '0 : wstrb;
    assign cmd.last    = (beats_left == '0);
    assign cmd_push    = cmd.valid && cmd.ready;

    // reads stream straight through, writes collapse into one B beat
    assign rsp.ready   = rsp.is_read ? rready : !bvalid;
    assign wr_rsp_take = rsp.valid && rsp.ready && !rsp.is_read;
    assign merged_resp = (rsp.resp > worst_resp) ? rsp.resp : worst_resp;

    assign rvalid = rsp.valid && rsp.is_read;
    assign rdata  = rsp.rdata;
    assign rresp  = rsp.resp;
    assign rlast  = rsp.last;
    assign rid    = id_q;
    assign bid    = id_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ST_IDLE;
            bvalid     <= 1'b0;
            rd_issued  <= 1'b0;
            worst_resp <= RESP_OKAY;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (awvalid) begin
                        state <= ST_WR_BEATS;
                    end else if (arvalid) begin
                        state     <= ST_RD_BEATS;
                        rd_issued <= 1'b0;
                    end
                end
                ST_WR_BEATS: if (cmd_push && cmd.last) state <= ST_WR_RESP;
                ST_WR_RESP: begin
                    if (bvalid && bready) begin
                        bvalid <= 1'b0;
                        state  <= ST_IDLE;
                    end
                end
                ST_RD_BEATS: begin
                    if (cmd_push && cmd.last) rd_issued <= 1'b1;
                    if (rvalid && rready && rlast) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
            if (wr_rsp_take) begin
                if (rsp.last) begin
                    bvalid     <= 1'b1;
                    worst_resp <= RESP_OKAY; // ready for the next burst
                end else begin
                    worst_resp <= merged_resp;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE) begin
            if (awvalid) begin
                id_q       <= awid;
                addr_q     <= awaddr;
                beats_left <= awlen[CNT_W-1:0];
            end else begin
                id_q       <= arid;
                addr_q     <= araddr;
                beats_left <= arlen[CNT_W-1:0];
            end
        end else if (cmd_push) begin
            addr_q     <= addr_q + addr_t'(`AXI_DATA_W / 8);
            beats_left <= beats_left - 1'b1;
        end
        if (wr_rsp_take && rsp.last) bresp <= merged_resp;
    end

    a_b_stable: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bid) && $stable(bresp));

    // master's wlast has to agree with the awlen count
    a_wlast_match: assert property (@(posedge clk) disable iff (reset)
        wvalid && wready |-> wlast == (beats_left == '0));

endmodule

// ==== verilog/led_register_file.sv ====
`timescale 1ns/100ps

`include "led_axi_config.svh"

module led_register_file import led_axi_pkg::*; (
    input  logic clk,
    input  logic reset,
    cmd_if.dst   cmd,
    rsp_if.src   rsp,
    output led_t led
);

    localparam int IDX_W = $clog2(`REG_COUNT);
    localparam int OFF_W = IDX_W + 2; // byte offset bits of the block

    data_t            regs [`REG_COUNT];
    logic [IDX_W-1:0] idx;
    logic             in_range;
    logic             take;

    assign idx      = cmd.addr[OFF_W-1:2];
    assign in_range = (cmd.addr[`AXI_ADDR_W-1:OFF_W] == '0);

    // one response slot, refilled in the cycle it drains
    assign cmd.ready = !rsp.valid || rsp.ready;
    assign take      = cmd.valid && cmd.ready;

    assign led = regs[0][`LED_W-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (take && !cmd.is_read && in_range) begin
            for (int b = 0; b < `AXI_DATA_W / 8; b++) begin
                if (cmd.wstrb[b]) regs[idx][8*b +: 8] <= cmd.wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp.valid <= 1'b0;
        end else if (take) begin
            rsp.valid <= 1'b1;
        end else if (rsp.ready) begin
            rsp.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            rsp.is_read <= cmd.is_read;
            rsp.last    <= cmd.last;
            rsp.resp    <= in_range ? RESP_OKAY : RESP_DECERR;
            // decode errors read back as zero
            rsp.rdata   <= (cmd.is_read && in_range) ? regs[idx] : '0;
        end
    end

    a_rsp_stable: assert property (@(posedge clk) disable iff (reset)
        rsp.valid && !rsp.ready |=> rsp.valid && $stable(rsp.rdata) &&
        $stable(rsp.resp) && $stable(rsp.last) && $stable(rsp.is_read));

endmodule

// ==== verilog/cmd_fifo.sv ====
`timescale 1ns/100ps

`include "led_axi_config.svh"

module cmd_fifo import led_axi_pkg::*; #(
    parameter int DEPTH = `CMD_FIFO_DEPTH
) (
    input  logic clk,
    input  logic reset,
    cmd_if.dst   wr,
    cmd_if.src   rd
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(DEPTH);

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    logic  mem_is_read [DEPTH];
    addr_t mem_addr    [DEPTH];
    data_t mem_wdata   [DEPTH];
    strb_t mem_wstrb   [DEPTH];
    logic  mem_last    [DEPTH];

    assign wr.ready = (count != FULL_COUNT);
    assign rd.valid = (count != '0);
    assign push     = wr.valid && wr.ready;
    assign pop      = rd.valid && rd.ready;

    // head entry drives the output directly
    assign rd.is_read = mem_is_read[rd_ptr];
    assign rd.addr    = mem_addr[rd_ptr];
    assign rd.wdata   = mem_wdata[rd_ptr];
    assign rd.wstrb   = mem_wstrb[rd_ptr];
    assign rd.last    = mem_last[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1; // wraps at DEPTH
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop) count <= count + 1'b1;
            else if (pop && !push) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem_is_read[wr_ptr] <= wr.is_read;
            mem_addr[wr_ptr]    <= wr.addr;
            mem_wdata[wr_ptr]   <= wr.wdata;
            mem_wstrb[wr_ptr]   <= wr.wstrb;
            mem_last[wr_ptr]    <= wr.last;
        end
    end

    // a write into a full buffer would clobber the stalled head
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        rd.valid && !rd.ready |=> rd.valid && $stable(rd.addr) && $stable(rd.wdata) &&
        $stable(rd.wstrb) && $stable(rd.last) && $stable(rd.is_read));

    // pointers and count agree, count never wraps below zero
    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        count <= FULL_COUNT && wr_ptr == rd_ptr + count[PTR_W-1:0]);

endmodule

// ==== verilog/led_axi_if.sv ====
`timescale 1ns/100ps

// one single-word register command
interface cmd_if import led_axi_pkg::*; ();

    logic  valid;
    logic  ready;
    logic  is_read;
    addr_t addr;
    data_t wdata;
    strb_t wstrb;
    logic  last;    // final beat of the burst

    modport src (
        output valid, is_read, addr, wdata, wstrb, last,
        input  ready
    );

    modport dst (
        input  valid, is_read, addr, wdata, wstrb, last,
        output ready
    );

endinterface

// one response beat back to the splitter
interface rsp_if import led_axi_pkg::*; ();

    logic  valid;
    logic  ready;
    logic  is_read;
    data_t rdata;
    resp_t resp;
    logic  last;

    modport src (
        output valid, is_read, rdata, resp, last,
        input  ready
    );

    modport dst (
        input  valid, is_read, rdata, resp, last,
        output ready
    );

endinterface

// ==== verilog/led_axi_pkg.sv ====
package led_axi_pkg;

`include "led_axi_config.svh"

    typedef logic [`AXI_ADDR_W-1:0]   addr_t; // byte address
    typedef logic [`AXI_DATA_W-1:0]   data_t;
    typedef logic [`AXI_DATA_W/8-1:0] strb_t;
    typedef logic [`AXI_ID_W-1:0]     id_t;
    typedef logic [`AXI_LEN_W-1:0]    len_t;  // beats minus one
    typedef logic [`LED_W-1:0]        led_t;

    // larger code is the worse response
    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_DECERR = 2'd3;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WR_BEATS,
        ST_WR_RESP,
        ST_RD_BEATS
    } splitter_state_t;

endpackage

// ==== verilog/led_axi_config.svh ====
`ifndef LED_AXI_CONFIG_SVH
`define LED_AXI_CONFIG_SVH

// AXI4 bus widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32
`define AXI_ID_W 4
`define AXI_LEN_W 8

// longest INCR burst accepted, in beats
`define MAX_BURST 16

// pending register commands between splitter and register file
`define CMD_FIFO_DEPTH 4

// register block
`define REG_COUNT 4
`define LED_W 4

`endif
